/* flist.f */
l2_cache_pkg.sv
l2_way_age.sv
l2_cache_control.sv
l2_cache_datapath.sv
l2_pmem_port.sv
l2_cache.sv
tb_clock_gen.sv
l2_cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module l2_cache_tb -f flist.f \
    && ./obj_dir/Vl2_cache_tb | tee /dev/stderr | grep -qx '>>> PASS' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* l2_cache_tb.sv */
// Testbench for the second-level cache
// Random requests, physical memory responder, reference cache model, compare tasks

`timescale 1ns/10ps

module l2_cache_tb;

    localparam int num_requests   = 300;
    localparam int timeout_cycles = num_requests * 20;
    localparam int drive_delay    = 1;
    localparam int age_max        = 255;

    logic                clk;
    logic                rst;
    logic                mem_read;
    logic                mem_write;
    l2_cache_pkg::addr_t mem_address;
    l2_cache_pkg::line_t mem_wdata;
    l2_cache_pkg::line_t mem_rdata;
    logic                mem_resp;
    logic                pmem_read;
    logic                pmem_write;
    l2_cache_pkg::addr_t pmem_address;
    l2_cache_pkg::line_t pmem_wdata;
    l2_cache_pkg::line_t pmem_rdata;
    logic                pmem_resp;

    // Reference cache state
    l2_cache_pkg::tag_t  model_tag   [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
    l2_cache_pkg::line_t model_data  [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
    logic                model_valid [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
    logic                model_dirty [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
    int                  model_age   [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];

    l2_cache_pkg::line_t phys_mem    [l2_cache_pkg::addr_t];
    l2_cache_pkg::line_t latest_data [l2_cache_pkg::addr_t];

    // Memory transfers seen by the responder during one request
    logic                ev_write [$];
    l2_cache_pkg::addr_t ev_addr  [$];
    l2_cache_pkg::line_t ev_data  [$];

    logic                exp_hit;
    logic                exp_wb;
    l2_cache_pkg::addr_t exp_wb_addr;
    l2_cache_pkg::line_t exp_wb_data;
    l2_cache_pkg::addr_t exp_fetch_addr;
    l2_cache_pkg::line_t exp_rdata;

    logic [31:0] rng_state = 32'h39ac;
    int checks = 0;
    int errors = 0;
    int test_checks = 0;
    int test_errors = 0;
    int tests = 0;
    int req_num = 0;
    int dirty_misses = 0;

    l2_cache_pkg::tag_t   tag_pool [6] = '{24'h000012, 24'h0a0034, 24'h5c0001,
                                          24'hff00ee, 24'h123456, 24'h00beef};
    l2_cache_pkg::index_t set_pool [2] = '{3'd2, 3'd5};

    tb_clock_gen clock_gen0
    (
        .clk (clk),
        .rst (rst)
    );

    l2_cache dut0
    (
        .clk          (clk),
        .rst          (rst),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic l2_cache_pkg::line_t random_line();
        l2_cache_pkg::line_t l;
        l = '0;
        repeat (8) l = {l[223:0], next_rand()};
        return l;
    endfunction

    // Initial memory contents, seeded by the full line address
    function automatic l2_cache_pkg::line_t pattern_line(input l2_cache_pkg::addr_t a);
        l2_cache_pkg::line_t l;
        logic [31:0]         x;
        l = '0;
        x = a ^ 32'h39ac;
        repeat (8)
        begin
            x = xorshift(x);
            l = {l[223:0], x};
        end
        return l;
    endfunction

    function automatic l2_cache_pkg::line_t memory_line(input l2_cache_pkg::addr_t a);
        if (!phys_mem.exists(a))
        begin
            phys_mem[a] = pattern_line(a);
        end
        return phys_mem[a];
    endfunction

    function automatic l2_cache_pkg::line_t latest_line(input l2_cache_pkg::addr_t a);
        if (!latest_data.exists(a))
        begin
            latest_data[a] = pattern_line(a);
        end
        return latest_data[a];
    endfunction

    function automatic l2_cache_pkg::addr_t random_address();
        logic [31:0] r;
        logic [2:0]  k;
        r = next_rand();
        k = 3'(r % 32'd6);
        return {tag_pool[k], set_pool[r[8]], r[20:16]};
    endfunction

    function automatic l2_cache_pkg::way_t choose_victim(input l2_cache_pkg::index_t idx);
        l2_cache_pkg::way_t v;
        l2_cache_pkg::way_t best;
        logic               found;
        found = 1'b0;
        best  = '0;
        for (int w = 0; w < l2_cache_pkg::num_ways; w++)
        begin
            v = l2_cache_pkg::way_t'(w);
            if (!found && !model_valid[idx][v])
            begin
                best  = v;
                found = 1'b1;
            end
        end
        // Full set: oldest way, ties stay on the lower number
        for (int w = 1; w < l2_cache_pkg::num_ways; w++)
        begin
            v = l2_cache_pkg::way_t'(w);
            if (!found && (model_age[idx][v] > model_age[idx][best]))
            begin
                best = v;
            end
        end
        return best;
    endfunction

    function automatic void touch_ages(input l2_cache_pkg::index_t idx,
                                       input l2_cache_pkg::way_t way);
        l2_cache_pkg::way_t v;
        for (int w = 0; w < l2_cache_pkg::num_ways; w++)
        begin
            v = l2_cache_pkg::way_t'(w);
            if (v == way)
            begin
                model_age[idx][v] = 0;
            end
            else if (model_valid[idx][v] && (model_age[idx][v] < age_max))
            begin
                model_age[idx][v] = model_age[idx][v] + 1;
            end
        end
    endfunction

    function automatic void predict_request(input logic is_write,
                                            input l2_cache_pkg::addr_t addr,
                                            input l2_cache_pkg::line_t wdata);
        l2_cache_pkg::index_t idx;
        l2_cache_pkg::tag_t   tag;
        l2_cache_pkg::addr_t  line_addr;
        l2_cache_pkg::way_t   v;
        l2_cache_pkg::way_t   way;
        idx       = addr[l2_cache_pkg::offset_bits +: l2_cache_pkg::index_bits];
        tag       = addr[31 -: l2_cache_pkg::tag_bits];
        line_addr = {addr[31:l2_cache_pkg::offset_bits], 5'b00000};
        exp_hit   = 1'b0;
        exp_wb    = 1'b0;
        way       = '0;
        for (int w = 0; w < l2_cache_pkg::num_ways; w++)
        begin
            v = l2_cache_pkg::way_t'(w);
            if (model_valid[idx][v] && (model_tag[idx][v] == tag))
            begin
                exp_hit = 1'b1;
                way     = v;
            end
        end
        exp_fetch_addr = line_addr;
        if (!exp_hit)
        begin
            way = choose_victim(idx);
            if (model_valid[idx][way] && model_dirty[idx][way])
            begin
                exp_wb      = 1'b1;
                exp_wb_addr = {model_tag[idx][way], idx, 5'b00000};
                exp_wb_data = model_data[idx][way];
            end
            model_tag[idx][way]   = tag;
            model_valid[idx][way] = 1'b1;
            model_dirty[idx][way] = 1'b0;
            model_data[idx][way]  = latest_line(line_addr);
        end
        if (is_write)
        begin
            model_data[idx][way]   = wdata;
            model_dirty[idx][way]  = 1'b1;
            latest_data[line_addr] = wdata;
        end
        exp_rdata = latest_line(line_addr);
        touch_ages(idx, way);
    endfunction

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic compare_line(input string name, input l2_cache_pkg::line_t got,
                                input l2_cache_pkg::line_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %s request %0d: got %h expected %h", name, req_num, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input l2_cache_pkg::addr_t got,
                                input l2_cache_pkg::addr_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %s request %0d: got %h expected %h", name, req_num, got, exp);
        end
    endtask

    // Optional write-back first, then exactly one fetch, or nothing on a hit
    task automatic check_pmem_events();
        int expected;
        expected = exp_hit ? 0 : (exp_wb ? 2 : 1);
        checks++;
        if (ev_write.size() != expected)
        begin
            report_failure($sformatf("request %0d: expected %0d memory transfers but saw %0d",
                                     req_num, expected, ev_write.size()));
        end
        else if (!exp_hit)
        begin
            if (exp_wb)
            begin
                if (!ev_write[0])
                begin
                    report_failure($sformatf("request %0d: write-back missing before fetch",
                                             req_num));
                end
                compare_addr("pmem_address", ev_addr[0], exp_wb_addr);
                compare_line("pmem_wdata", ev_data[0], exp_wb_data);
            end
            if (ev_write[expected - 1])
            begin
                report_failure($sformatf("request %0d: unexpected pmem write instead of a fetch",
                                         req_num));
            end
            compare_addr("pmem_address", ev_addr[expected - 1], exp_fetch_addr);
        end
    endtask

    task automatic run_request(input logic is_write, input l2_cache_pkg::addr_t addr);
        l2_cache_pkg::line_t wdata;
        int                  cycles;
        wdata = random_line();
        predict_request(is_write, addr, wdata);
        ev_write.delete();
        ev_addr.delete();
        ev_data.delete();
        @(posedge clk);
        #drive_delay;
        mem_read    = !is_write;
        mem_write   = is_write;
        mem_address = addr;
        mem_wdata   = wdata;
        cycles      = 0;
        @(negedge clk);
        while (!mem_resp)
        begin
            cycles++;
            @(negedge clk);
        end
        if (!is_write)
        begin
            compare_line("mem_rdata", mem_rdata, exp_rdata);
        end
        checks++;
        if ((cycles == 0) || (exp_hit && (cycles != 1)))
        begin
            report_failure($sformatf("request %0d: answered %0d cycles after the request",
                                     req_num, cycles));
        end
        @(posedge clk);
        #drive_delay;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        @(negedge clk);
        if (mem_resp)
        begin
            report_failure($sformatf("request %0d: mem_resp longer than one cycle", req_num));
        end
        check_pmem_events();
        if (exp_wb)
        begin
            dirty_misses++;
        end
        req_num++;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
        tests++;
    endtask

    // Physical memory with a random delay of 1 to 4 cycles
    initial
    begin : memory_responder
        int                  remaining;
        logic                busy;
        logic                fire;
        logic [31:0]         r;
        l2_cache_pkg::line_t fire_data;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        busy       = 1'b0;
        remaining  = 0;
        fire_data  = '0;
        forever
        begin
            @(negedge clk);
            fire = 1'b0;
            if (pmem_read && pmem_write)
            begin
                report_failure("pmem_read and pmem_write raised together");
            end
            if (pmem_resp)
            begin
                busy = 1'b0;
                if (pmem_write)
                begin
                    phys_mem[pmem_address] = pmem_wdata;
                end
                if (pmem_read || pmem_write)
                begin
                    ev_write.push_back(pmem_write);
                    ev_addr.push_back(pmem_address);
                    ev_data.push_back(pmem_wdata);
                end
            end
            else if (!rst && (pmem_read || pmem_write))
            begin
                if (!busy)
                begin
                    r         = next_rand();
                    busy      = 1'b1;
                    remaining = 1 + int'(r[1:0]);
                end
                remaining--;
                if (remaining == 0)
                begin
                    fire = 1'b1;
                    if (pmem_read)
                    begin
                        fire_data = memory_line(pmem_address);
                    end
                end
            end
            @(posedge clk);
            #drive_delay;
            pmem_resp = fire;
            if (fire)
            begin
                pmem_rdata = fire_data;
            end
        end
    end

    initial
    begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < timeout_cycles)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles while request %0d was open", cycle_count, req_num);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin : stimulus
        logic [31:0] r;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        model_valid = '{default: 1'b0};
        model_dirty = '{default: 1'b0};
        model_age   = '{default: 0};
        @(negedge rst);
        repeat (3)
        begin
            @(negedge clk);
            checks++;
            if (mem_resp || pmem_read || pmem_write)
            begin
                report_failure("a response or memory strobe rose before any request");
            end
        end
        end_test("reset_idle");
        run_request(1'b0, random_address());
        end_test("cold_read_miss");
        repeat (num_requests - 1)
        begin
            r = next_rand();
            run_request(r[0], random_address());
        end
        checks++;
        if (dirty_misses == 0)
        begin
            report_failure("the random traffic never caused a dirty write-back");
        end
        end_test("random_traffic");
        $display("summary: %0d tests, %0d requests, %0d checks, %0d errors",
                 tests, req_num, checks, errors);
        if (errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : l2_cache_tb

/* tb_clock_gen.sv */
// Testbench clock and reset source
// 40 ns clock, reset held for five rising edges

`timescale 1ns/10ps

module tb_clock_gen
(
    output logic clk,
    output logic rst
);

    localparam int half_period  = 20;
    localparam int reset_cycles = 5;

    initial
    begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule : tb_clock_gen

/* l2_cache.sv */
// Second-level cache top level
// Connects the controller, the datapath and the memory port

`timescale 1ns/10ps

module l2_cache
(
    input  logic                clk,
    input  logic                rst,

    input  logic                mem_read,
    input  logic                mem_write,
    input  l2_cache_pkg::addr_t mem_address,
    input  l2_cache_pkg::line_t mem_wdata,
    output l2_cache_pkg::line_t mem_rdata,
    output logic                mem_resp,

    output logic                pmem_read,
    output logic                pmem_write,
    output l2_cache_pkg::addr_t pmem_address,
    output l2_cache_pkg::line_t pmem_wdata,
    input  l2_cache_pkg::line_t pmem_rdata,
    input  logic                pmem_resp
);

    logic                         hit;
    logic                         victim_dirty;
    logic                         line_load;
    logic                         fill;
    logic                         cpu_write;
    logic                         evict;
    logic                         age_touch;
    l2_cache_pkg::pmem_addr_sel_t pmem_address_sel;
    l2_cache_pkg::tag_t           victim_tag;
    l2_cache_pkg::line_t          fill_line;

    l2_cache_control control0
    (
        .clk              (clk),
        .rst              (rst),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_resp         (mem_resp),
        .pmem_resp        (pmem_resp),
        .pmem_read        (pmem_read),
        .pmem_write       (pmem_write),
        .hit              (hit),
        .victim_dirty     (victim_dirty),
        .line_load        (line_load),
        .fill             (fill),
        .cpu_write        (cpu_write),
        .evict            (evict),
        .age_touch        (age_touch),
        .pmem_address_sel (pmem_address_sel)
    );

    // Way numbers stay inside the datapath
    l2_cache_datapath datapath0
    (
        .clk          (clk),
        .rst          (rst),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .fill_line    (fill_line),
        .cpu_write    (cpu_write),
        .fill         (fill),
        .evict        (evict),
        .age_touch    (age_touch),
        .hit          (hit),
        .hit_way      (),
        .victim_way   (),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .mem_rdata    (mem_rdata),
        .victim_line  (pmem_wdata)
    );

    l2_pmem_port pmem_port0
    (
        .clk              (clk),
        .rst              (rst),
        .line_load        (line_load),
        .pmem_rdata       (pmem_rdata),
        .pmem_address_sel (pmem_address_sel),
        .mem_address      (mem_address),
        .victim_tag       (victim_tag),
        .fill_line        (fill_line),
        .pmem_address     (pmem_address)
    );

endmodule : l2_cache

/* l2_pmem_port.sv */
// Physical memory port
// Line buffer for fetched lines and memory address select

`timescale 1ns/10ps

module l2_pmem_port
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         line_load,
    input  l2_cache_pkg::line_t          pmem_rdata,
    input  l2_cache_pkg::pmem_addr_sel_t pmem_address_sel,
    input  l2_cache_pkg::addr_t          mem_address,
    input  l2_cache_pkg::tag_t           victim_tag,
    output l2_cache_pkg::line_t          fill_line,
    output l2_cache_pkg::addr_t          pmem_address
);

    l2_cache_pkg::line_t    line_buf;
    l2_cache_pkg::index_t   req_index;

    assign req_index = mem_address[l2_cache_pkg::offset_bits +: l2_cache_pkg::index_bits];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            line_buf <= '0;
        end
        else if (line_load)
        begin
            line_buf <= pmem_rdata;
        end
    end

    assign fill_line = line_buf;

    // Both addresses are line aligned
    always_comb
    begin
        if (pmem_address_sel == l2_cache_pkg::addr_writeback)
        begin
            pmem_address = {victim_tag, req_index, {l2_cache_pkg::offset_bits{1'b0}}};
        end
        else
        begin
            pmem_address = {mem_address[31:l2_cache_pkg::offset_bits],
                            {l2_cache_pkg::offset_bits{1'b0}}};
        end
    end

endmodule : l2_pmem_port

/* l2_cache_datapath.sv */
// Tag, valid, dirty and data arrays of the four-way cache
// Hit detection, read-data and victim selection

`timescale 1ns/10ps

module l2_cache_datapath
(
    input  logic                clk,
    input  logic                rst,

    input  l2_cache_pkg::addr_t mem_address,
    input  l2_cache_pkg::line_t mem_wdata,
    input  l2_cache_pkg::line_t fill_line,

    input  logic                cpu_write,
    input  logic                fill,
    input  logic                evict,
    input  logic                age_touch,

    output logic                hit,
    output l2_cache_pkg::way_t  hit_way,
    output l2_cache_pkg::way_t  victim_way,
    output logic                victim_dirty,
    output l2_cache_pkg::tag_t  victim_tag,
    output l2_cache_pkg::line_t mem_rdata,
    output l2_cache_pkg::line_t victim_line
);

    localparam int tag_lsb = l2_cache_pkg::offset_bits + l2_cache_pkg::index_bits;

    l2_cache_pkg::tag_t      tag_array  [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
    l2_cache_pkg::line_t     data_array [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
    l2_cache_pkg::way_mask_t valid      [l2_cache_pkg::num_sets];
    l2_cache_pkg::way_mask_t dirty      [l2_cache_pkg::num_sets];

    l2_cache_pkg::tag_t      req_tag;
    l2_cache_pkg::index_t    req_index;
    l2_cache_pkg::way_mask_t hit_mask;

    assign req_index = mem_address[l2_cache_pkg::offset_bits +: l2_cache_pkg::index_bits];
    assign req_tag   = mem_address[tag_lsb +: l2_cache_pkg::tag_bits];

    // Tag compare across all ways of the set
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < l2_cache_pkg::num_ways; w++)
        begin
            hit_mask[w] = valid[req_index][w] && (tag_array[req_index][w] == req_tag);
        end
        for (int w = l2_cache_pkg::num_ways - 1; w >= 0; w--)
        begin
            if (hit_mask[w])
            begin
                hit_way = l2_cache_pkg::way_t'(w);
            end
        end
    end

    assign hit = |hit_mask;

    assign mem_rdata    = data_array[req_index][hit_way];
    assign victim_line  = data_array[req_index][victim_way];
    assign victim_tag   = tag_array[req_index][victim_way];
    assign victim_dirty = valid[req_index][victim_way] & dirty[req_index][victim_way];

    always_ff @(posedge clk)
    begin
        if (cpu_write)
        begin
            data_array[req_index][hit_way] <= mem_wdata;
        end
        else if (fill)
        begin
            data_array[req_index][victim_way] <= fill_line;
            tag_array[req_index][victim_way]  <= req_tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < l2_cache_pkg::num_sets; s++)
            begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end
        else if (cpu_write)
        begin
            dirty[req_index][hit_way] <= 1'b1;
        end
        else if (fill)
        begin
            valid[req_index][victim_way] <= 1'b1;
            dirty[req_index][victim_way] <= 1'b0;
        end
        else if (evict)
        begin
            // Written back, so the way is free for the fetch
            valid[req_index][victim_way] <= 1'b0;
        end
    end

    l2_way_age way_age0
    (
        .clk        (clk),
        .rst        (rst),
        .index      (req_index),
        .valid_mask (valid[req_index]),
        .age_touch  (age_touch),
        .touch_way  (hit_way),
        .victim_way (victim_way)
    );

endmodule : l2_cache_datapath

/* l2_cache_control.sv */
// Cache controller FSM
// Sequences lookup, victim write-back, line fetch and fill

`timescale 1ns/10ps

module l2_cache_control
(
    input  logic clk,
    input  logic rst,

    // Requester side
    input  logic mem_read,
    input  logic mem_write,
    output logic mem_resp,

    // Physical memory side
    input  logic pmem_resp,
    output logic pmem_read,
    output logic pmem_write,

    // Datapath status
    input  logic hit,
    input  logic victim_dirty,

    // Datapath strobes
    output logic line_load,
    output logic fill,
    output logic cpu_write,
    output logic evict,
    output logic age_touch,
    output l2_cache_pkg::pmem_addr_sel_t pmem_address_sel
);

    l2_cache_pkg::ctrl_state_t state;
    l2_cache_pkg::ctrl_state_t next_state;

    always_comb
    begin : state_actions
        mem_resp         = 1'b0;
        pmem_read        = 1'b0;
        pmem_write       = 1'b0;
        line_load        = 1'b0;
        fill             = 1'b0;
        cpu_write        = 1'b0;
        evict            = 1'b0;
        age_touch        = 1'b0;
        pmem_address_sel = l2_cache_pkg::addr_fetch;

        case (state)
            l2_cache_pkg::idle:
            begin
            end
            l2_cache_pkg::lookup:
            begin
                mem_resp  = hit;
                age_touch = hit;
                // Write hit lands in the hit way at the end of this cycle
                cpu_write = hit & mem_write;
            end
            l2_cache_pkg::write_back:
            begin
                pmem_write       = 1'b1;
                pmem_address_sel = l2_cache_pkg::addr_writeback;
                evict            = pmem_resp;
            end
            l2_cache_pkg::fetch:
            begin
                pmem_read        = 1'b1;
                pmem_address_sel = l2_cache_pkg::addr_fetch;
                line_load        = pmem_resp;
            end
            l2_cache_pkg::fill:
            begin
                fill = 1'b1;
            end
            default:
            begin
            end
        endcase
    end

    always_comb
    begin : next_state_logic
        next_state = state;

        case (state)
            l2_cache_pkg::idle:
            begin
                if (mem_read || mem_write)
                begin
                    next_state = l2_cache_pkg::lookup;
                end
            end
            l2_cache_pkg::lookup:
            begin
                if (hit)
                begin
                    next_state = l2_cache_pkg::idle;
                end
                else if (victim_dirty)
                begin
                    next_state = l2_cache_pkg::write_back;
                end
                else
                begin
                    next_state = l2_cache_pkg::fetch;
                end
            end
            l2_cache_pkg::write_back:
            begin
                if (pmem_resp)
                begin
                    next_state = l2_cache_pkg::fetch;
                end
            end
            l2_cache_pkg::fetch:
            begin
                if (pmem_resp)
                begin
                    next_state = l2_cache_pkg::fill;
                end
            end
            l2_cache_pkg::fill:
            begin
                // Look again, which now hits
                next_state = l2_cache_pkg::lookup;
            end
            default:
            begin
                next_state = l2_cache_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin : state_register
        if (rst)
        begin
            state <= l2_cache_pkg::idle;
        end
        else
        begin
            state <= next_state;
        end
    end

endmodule : l2_cache_control

/* l2_way_age.sv */
// Per-set saturating way ages
// Victim choice, invalid first, then oldest, then lowest way

`timescale 1ns/10ps

module l2_way_age
(
    input  logic                    clk,
    input  logic                    rst,
    input  l2_cache_pkg::index_t    index,
    input  l2_cache_pkg::way_mask_t valid_mask,
    input  logic                    age_touch,
    input  l2_cache_pkg::way_t      touch_way,
    output l2_cache_pkg::way_t      victim_way
);

    l2_cache_pkg::age_t ages [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < l2_cache_pkg::num_sets; s++)
            begin
                for (int w = 0; w < l2_cache_pkg::num_ways; w++)
                begin
                    ages[s][w] <= '0;
                end
            end
        end
        else if (age_touch)
        begin
            for (int w = 0; w < l2_cache_pkg::num_ways; w++)
            begin
                if (l2_cache_pkg::way_t'(w) == touch_way)
                begin
                    ages[index][w] <= '0;
                end
                else if (valid_mask[w] && (ages[index][w] != '1))
                begin
                    ages[index][w] <= ages[index][w] + l2_cache_pkg::age_t'(1);
                end
            end
        end
    end

    always_comb
    begin
        l2_cache_pkg::age_t best_age;

        best_age   = ages[index][0];
        victim_way = '0;
        // Strict compare keeps ties on the lower way
        for (int w = 1; w < l2_cache_pkg::num_ways; w++)
        begin
            if (ages[index][w] > best_age)
            begin
                best_age   = ages[index][w];
                victim_way = l2_cache_pkg::way_t'(w);
            end
        end
        // Any invalid way wins, lowest number last
        for (int w = l2_cache_pkg::num_ways - 1; w >= 0; w--)
        begin
            if (!valid_mask[w])
            begin
                victim_way = l2_cache_pkg::way_t'(w);
            end
        end
    end

endmodule : l2_way_age

/* l2_cache_pkg.sv */
// Geometry constants for the second-level cache
// Vector typedefs for addresses, lines, tags, ways and ages
// Enums for the memory address select and the controller FSM

package l2_cache_pkg;

    localparam int num_ways    = 4;
    localparam int num_sets    = 8;
    localparam int offset_bits = 5;
    localparam int index_bits  = 3;
    localparam int tag_bits    = 24;

    typedef logic [31:0]  addr_t;
    typedef logic [255:0] line_t;
    typedef logic [23:0]  tag_t;
    typedef logic [2:0]   index_t;
    typedef logic [1:0]   way_t;
    typedef logic [3:0]   way_mask_t;
    typedef logic [7:0]   age_t;

    // Source of the physical memory address
    typedef enum logic {
        addr_fetch,
        addr_writeback
    } pmem_addr_sel_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        fetch,
        fill,
        write_back
    } ctrl_state_t;

endpackage : l2_cache_pkg
